// File: Bender.yml
package:
  name: pkt_parser

sources:
  - common/parser_pkg.sv
  - common/field_if.sv
  - src/seg_counter.sv
  - src/parse_fsm.sv
  - src/hdr_buffer.sv
  - extract/field_extractor.sv
  - extract/phv_assembler.sv
  - table/action_ram.sv
  - table/ctrl_table_writer.sv
  - src/parser_top.sv
  - target: test
    files:
      - bench/parser_tb.sv

// File: bench/parser_tb.sv
`default_nettype none
`timescale 1ns/10ps

module parser_tb;
    import parser_pkg::*;

    localparam logic [2:0] MY_ID       = 3'd2;
    localparam int         TIMEOUT_CYC = 100;

    logic   axis_clk;
    logic   aresetn;
    data_t  s_axis_tdata_i;
    logic   s_axis_tvalid_i;
    logic   s_axis_tlast_i;
    logic   s_axis_tready_o;
    logic   phv_valid_o;
    phv_t   phv_o;
    logic   m_axis_tready_i;
    data_t  c_s_axis_tdata_i;
    logic   c_s_axis_tvalid_i;
    logic   c_s_axis_tlast_i;

    // reference copy of the action table
    entry_t tbl_model [TBL_DEPTH];
    int     written [$];
    phv_t   exp_phv;
    int     value_errs = 0;
    int     proto_errs = 0;
    int     pulse_cnt  = 0;

    parser_top #(
        .PARSER_ID(MY_ID)
    ) DUT (
        .axis_clk         (axis_clk),
        .aresetn          (aresetn),
        .s_axis_tdata_i   (s_axis_tdata_i),
        .s_axis_tvalid_i  (s_axis_tvalid_i),
        .s_axis_tlast_i   (s_axis_tlast_i),
        .s_axis_tready_o  (s_axis_tready_o),
        .phv_valid_o      (phv_valid_o),
        .phv_o            (phv_o),
        .m_axis_tready_i  (m_axis_tready_i),
        .c_s_axis_tdata_i (c_s_axis_tdata_i),
        .c_s_axis_tvalid_i(c_s_axis_tvalid_i),
        .c_s_axis_tlast_i (c_s_axis_tlast_i)
    );

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    always @(negedge axis_clk) begin
        if (aresetn && phv_valid_o) begin
            pulse_cnt++;
        end
    end

    a_phv_value: assert property (@(posedge axis_clk) disable iff (!aresetn)
        phv_valid_o |-> phv_o == exp_phv)
    else begin
        value_errs++;
        $display("ERROR %0t: PHV differs from the reference model", $time);
    end

    a_pulse_width: assert property (@(posedge axis_clk) disable iff (!aresetn)
        phv_valid_o |=> !phv_valid_o)
    else begin
        proto_errs++;
        $display("ERROR %0t: phv_valid_o high for more than one cycle", $time);
    end

    a_hold_valid: assert property (@(posedge axis_clk) disable iff (!aresetn)
        !m_axis_tready_i |=> !phv_valid_o)
    else begin
        proto_errs++;
        $display("ERROR %0t: phv_valid_o raised under back-pressure", $time);
    end

    a_hold_tready: assert property (@(posedge axis_clk) disable iff (!aresetn)
        !s_axis_tready_o && !m_axis_tready_i |=> !s_axis_tready_o)
    else begin
        proto_errs++;
        $display("ERROR %0t: s_axis_tready_o rose under back-pressure", $time);
    end

    // PHV leaves three cycles after the first-beat edge
    a_latency: assert property (@(posedge axis_clk) disable iff (!aresetn)
        $rose(s_axis_tvalid_i) && m_axis_tready_i |-> ##4 phv_valid_o)
    else begin
        proto_errs++;
        $display("ERROR %0t: PHV not emitted at the expected cycle", $time);
    end

    function automatic logic [15:0] make_act(input int off, input logic [1:0] kind,
                                             input int idx, input bit en);
        return {3'b000, 7'(off), kind, 3'(idx), en};
    endfunction

    function automatic data_t rand_beat();
        data_t d;
        for (int w = 0; w < DATA_W/32; w++) begin
            d[32*w +: 32] = $urandom;
        end
        return d;
    endfunction

    function automatic entry_t rand_entry();
        entry_t e;
        for (int s = 0; s < NUM_ACT; s++) begin
            e[ENTRY_W-1-ACT_W*s -: ACT_W] = make_act($urandom_range(0, 127),
                2'($urandom_range(0, 3)), $urandom_range(0, 7), 1'($urandom_range(0, 1)));
        end
        return e;
    endfunction

    // bytes past the end of the header read as zero
    function automatic logic [7:0] hdr_byte(input hdr_t h, input int i);
        if (i > HDR_W/8 - 1) begin
            return 8'h00;
        end
        return h[8*i +: 8];
    endfunction

    function automatic phv_t expect_phv(input hdr_t h, input entry_t e);
        logic [47:0] c6 [8];
        logic [31:0] c4 [8];
        logic [15:0] c2 [8];
        logic [15:0] act;
        logic [47:0] v;
        int          nbytes;
        phv_t        p;
        for (int k = 0; k < 8; k++) begin
            c6[k] = '0;
            c4[k] = '0;
            c2[k] = '0;
        end
        // slots in order, so the higher slot wins a shared container
        for (int s = 0; s < NUM_ACT; s++) begin
            act = e[ENTRY_W-1-ACT_W*s -: ACT_W];
            if (act[0]) begin
                nbytes = (act[5:4] == 2'd1) ? 2 : (act[5:4] == 2'd2) ? 4 :
                         (act[5:4] == 2'd3) ? 6 : 0;
                v = '0;
                for (int b = 0; b < nbytes; b++) begin
                    v = {v[39:0], hdr_byte(h, int'(act[12:6]) + b)};
                end
                case (act[5:4])
                    2'd1:    c2[act[3:1]] = v[15:0];
                    2'd2:    c4[act[3:1]] = v[31:0];
                    2'd3:    c6[act[3:1]] = v;
                    default: ;
                endcase
            end
        end
        p = '0;
        for (int k = 0; k < 8; k++) begin
            p[PHV_W-1-48*(7-k) -: 48]   = c6[k];
            p[PHV_W-385-32*(7-k) -: 32] = c4[k];
            p[PHV_W-641-16*(7-k) -: 16] = c2[k];
        end
        p[PHV_W-769-115 -: 12] = h[VLAN_LSB +: 12];
        return p;
    endfunction

    task automatic report_counts();
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
    endtask

    task automatic timeout_exit(input string what);
        $display("timed out waiting for %s at %0t", what, $time);
        report_counts();
        $display("sim failed");
        $finish;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!s_axis_tready_o && n < TIMEOUT_CYC) begin
            @(negedge axis_clk);
            n++;
        end
        if (!s_axis_tready_o) begin
            timeout_exit("s_axis_tready_o");
        end
    endtask

    task automatic wait_phv();
        int n;
        n = 0;
        while (!phv_valid_o && n < TIMEOUT_CYC) begin
            @(negedge axis_clk);
            n++;
        end
        if (!phv_valid_o) begin
            timeout_exit("phv_valid_o");
        end
    endtask

    // header beat, then one entry per beat; apply marks a packet the DUT must take
    task automatic send_ctrl(input logic [2:0] id, input logic [15:0] flag,
                             input int first_idx, input entry_t ents[$], input bit apply);
        data_t beat;
        beat = rand_beat();
        beat[MOD_ID_LSB +: 3]     = id;
        beat[CTRL_FLAG_LSB +: 16] = flag;
        beat[INDEX_LSB +: 8]      = 8'(first_idx);
        c_s_axis_tdata_i  = beat;
        c_s_axis_tvalid_i = 1'b1;
        c_s_axis_tlast_i  = 1'b0;
        @(negedge axis_clk);
        foreach (ents[i]) begin
            beat = rand_beat();
            for (int j = 0; j < ENTRY_W/8; j++) begin
                beat[8*j +: 8] = ents[i][ENTRY_W-1-8*j -: 8];
            end
            c_s_axis_tdata_i = beat;
            c_s_axis_tlast_i = (i == ents.size() - 1);
            @(negedge axis_clk);
            if (apply) begin
                tbl_model[(first_idx + i) % TBL_DEPTH] = ents[i];
                written.push_back((first_idx + i) % TBL_DEPTH);
            end
        end
        c_s_axis_tvalid_i = 1'b0;
        c_s_axis_tlast_i  = 1'b0;
        repeat (3) @(negedge axis_clk);
    endtask

    task automatic parse_packet(input int tbl_idx, input bit two_beats, input int hold_cycles);
        hdr_t h;
        int   pulses_before;
        h = {rand_beat(), rand_beat()};
        h[VLAN_LSB+4 +: 5] = 5'(tbl_idx);
        if (!two_beats) begin
            h[HDR_W-1:DATA_W] = '0;
        end
        exp_phv = expect_phv(h, tbl_model[tbl_idx]);
        wait_ready();
        pulses_before = pulse_cnt;
        if (hold_cycles > 0) begin
            m_axis_tready_i = 1'b0;
        end
        s_axis_tdata_i  = h[DATA_W-1:0];
        s_axis_tvalid_i = 1'b1;
        s_axis_tlast_i  = !two_beats;
        @(negedge axis_clk);
        if (two_beats) begin
            s_axis_tdata_i = h[HDR_W-1:DATA_W];
            s_axis_tlast_i = 1'b1;
            @(negedge axis_clk);
        end
        s_axis_tvalid_i = 1'b0;
        s_axis_tlast_i  = 1'b0;
        s_axis_tdata_i  = rand_beat();
        if (hold_cycles > 0) begin
            repeat (hold_cycles) @(negedge axis_clk);
            assert (pulse_cnt == pulses_before && !s_axis_tready_o) else begin
                proto_errs++;
                $display("ERROR %0t: parser did not hold the PHV under back-pressure", $time);
            end
            m_axis_tready_i = 1'b1;
        end
        wait_phv();
        repeat (4) @(negedge axis_clk);
        assert (pulse_cnt == pulses_before + 1) else begin
            proto_errs++;
            $display("ERROR %0t: %0d PHV pulses for one packet", $time,
                     pulse_cnt - pulses_before);
        end
    endtask

    initial begin
        entry_t ents [$];
        void'($urandom(32'hddde2b09));
        aresetn           = 1'b0;
        s_axis_tdata_i    = '0;
        s_axis_tvalid_i   = 1'b0;
        s_axis_tlast_i    = 1'b0;
        m_axis_tready_i   = 1'b1;
        c_s_axis_tdata_i  = '0;
        c_s_axis_tvalid_i = 1'b0;
        c_s_axis_tlast_i  = 1'b0;
        repeat (10) @(negedge axis_clk);
        aresetn = 1'b1;
        @(negedge axis_clk);
        assert (!phv_valid_o && s_axis_tready_o) else begin
            proto_errs++;
            $display("ERROR %0t: wrong output levels after reset", $time);
        end

        // entry 5 has a disabled slot and slots 2 and 7 on one container
        ents = {};
        ents.push_back({make_act(14, C6B, 0, 1), make_act(20, C4B, 3, 1),
                        make_act(30, C2B, 5, 1), make_act(40, C6B, 7, 0),
                        make_act(1, C2B, 0, 1),  make_act(50, C4B, 7, 1),
                        make_act(0, NONE, 0, 0), make_act(33, C2B, 5, 1),
                        make_act(58, C6B, 2, 1), make_act(10, C2B, 6, 0)});
        // entry 6 reads the second beat and past the header end
        ents.push_back({make_act(64, C6B, 1, 1),  make_act(70, C4B, 0, 1),
                        make_act(100, C2B, 2, 1), make_act(124, C6B, 4, 1),
                        make_act(126, C4B, 5, 1), make_act(127, C2B, 7, 1),
                        make_act(90, C6B, 6, 1),  make_act(60, C6B, 3, 1),
                        make_act(110, C4B, 1, 1), make_act(80, C4B, 1, 1)});
        ents.push_back(rand_entry());
        ents.push_back(rand_entry());
        send_ctrl(MY_ID, CTRL_FLAG, 5, ents, 1'b1);

        parse_packet(5, 1'b1, 0);
        parse_packet(6, 1'b1, 0);
        parse_packet(6, 1'b0, 0);
        parse_packet(7, 1'b1, 0);
        parse_packet(8, 1'b0, 0);
        parse_packet(5, 1'b1, 12);

        // foreign ID and a bad flag must not touch the table
        ents = {};
        ents.push_back(rand_entry());
        ents.push_back(rand_entry());
        send_ctrl(MY_ID + 3'd1, CTRL_FLAG, 5, ents, 1'b0);
        send_ctrl(MY_ID, ~CTRL_FLAG, 6, ents, 1'b0);
        parse_packet(5, 1'b1, 0);
        parse_packet(6, 1'b1, 0);

        // index wraps from 31 to 0
        ents = {};
        repeat (3) ents.push_back(rand_entry());
        send_ctrl(MY_ID, CTRL_FLAG, 30, ents, 1'b1);
        parse_packet(30, 1'b1, 0);
        parse_packet(31, 1'b0, 0);
        parse_packet(0, 1'b1, 3);

        repeat (10) begin
            parse_packet(written[$urandom_range(0, written.size() - 1)],
                         1'($urandom_range(0, 1)), 0);
        end

        report_counts();
        if (value_errs + proto_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: common/field_if.sv
`default_nettype none
`timescale 1ns/10ps

interface field_if;
    import parser_pkg::*;

    // one extracted field and where it goes
    field_val_t val;
    cont_type_e ctype;
    cont_idx_t  idx;
    logic       valid;

    modport src (output val, output ctype, output idx, output valid);
    modport dst (input val, input ctype, input idx, input valid);

endinterface

`default_nettype wire

// File: common/parser_pkg.sv
`default_nettype none

package parser_pkg;

    // stream, header and PHV widths
    localparam int DATA_W    = 512;
    localparam int HDR_W     = 1024;
    localparam int PHV_W     = 1024;

    // parse action table geometry
    localparam int NUM_ACT   = 10;
    localparam int ACT_W     = 16;
    localparam int ENTRY_W   = NUM_ACT * ACT_W;
    localparam int TBL_DEPTH = 32;

    typedef logic [DATA_W-1:0]            data_t;
    typedef logic [HDR_W-1:0]             hdr_t;
    typedef logic [PHV_W-1:0]             phv_t;
    typedef logic [ENTRY_W-1:0]           entry_t;
    typedef logic [$clog2(TBL_DEPTH)-1:0] tbl_addr_t;
    typedef logic [11:0]                  vlan_t;
    typedef logic [47:0]                  field_val_t;
    typedef logic [2:0]                   cont_idx_t;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        C2B  = 2'd1,
        C4B  = 2'd2,
        C6B  = 2'd3
    } cont_type_e;

    typedef enum logic [2:0] {
        IDLE_S,
        WAIT1_S,
        WAIT2_S,
        PHVGEN_S,
        HALT_S
    } parse_state_e;

    // control packet fields, bit offsets within the first beat
    localparam logic [15:0] CTRL_FLAG     = 16'hf2f1;
    localparam int          CTRL_FLAG_LSB = 320;
    localparam int          MOD_ID_LSB    = 368;
    localparam int          INDEX_LSB     = 384;

    // VLAN ID position in the first data beat
    localparam int          VLAN_LSB      = 116;

endpackage

`default_nettype wire

// File: extract/field_extractor.sv
`default_nettype none
`timescale 1ns/10ps

module field_extractor (
    input  wire                     axis_clk,
    input  wire                     aresetn,
    input  wire parser_pkg::hdr_t   hdr_i,
    input  wire [parser_pkg::ACT_W-1:0] action_i,
    input  wire                     start_i,
    field_if.src                    fld
);
    import parser_pkg::*;

    localparam int VAL_W = $bits(field_val_t);

    logic [6:0]           byte_off;
    logic [HDR_W+VAL_W-1:0] hdr_ext;

    // action layout: offset 12:6, type 5:4, index 3:1, valid 0
    assign byte_off = action_i[12:6];

    // pad so a field near the end reads zeros past byte 127
    assign hdr_ext = {{VAL_W{1'b0}}, hdr_i};

    // byte at the offset lands in the low byte here
    always_ff @(posedge axis_clk) begin
        if (start_i) begin
            fld.val <= hdr_ext[{byte_off, 3'b000} +: VAL_W];
        end
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            fld.ctype <= NONE;
            fld.idx   <= '0;
            fld.valid <= 1'b0;
        end else if (start_i) begin
            fld.ctype <= cont_type_e'(action_i[5:4]);
            fld.idx   <= action_i[3:1];
            fld.valid <= action_i[0];
        end
    end

endmodule

`default_nettype wire

// File: extract/phv_assembler.sv
`default_nettype none
`timescale 1ns/10ps

module phv_assembler (
    input  wire                    axis_clk,
    input  wire                    aresetn,
    input  wire                    clear_i,
    input  wire                    load_i,
    input  wire parser_pkg::vlan_t vlan_i,
    field_if.dst                   fld [parser_pkg::NUM_ACT],
    output parser_pkg::phv_t       phv_o
);
    import parser_pkg::*;

    localparam int NUM_CONT = 8;
    localparam int PAD_HI_W = 115;
    localparam int PAD_LO_W = 129;

    field_val_t           f_val   [NUM_ACT];
    cont_type_e           f_type  [NUM_ACT];
    cont_idx_t            f_idx   [NUM_ACT];
    logic [NUM_ACT-1:0]   f_valid;
    logic [47:0]          cont_6b [NUM_CONT];
    logic [31:0]          cont_4b [NUM_CONT];
    logic [15:0]          cont_2b [NUM_CONT];
    logic [NUM_CONT*48-1:0] pack_6b;
    logic [NUM_CONT*32-1:0] pack_4b;
    logic [NUM_CONT*16-1:0] pack_2b;

    // reverse the low nbytes of v
    function automatic field_val_t byte_swap(input field_val_t v, input int nbytes);
        field_val_t r;
        r = '0;
        for (int b = 0; b < nbytes; b++) begin
            r[8*(nbytes-1-b) +: 8] = v[8*b +: 8];
        end
        return r;
    endfunction

    for (genvar g = 0; g < NUM_ACT; g++) begin : g_unpack
        assign f_val[g]   = fld[g].val;
        assign f_type[g]  = fld[g].ctype;
        assign f_idx[g]   = fld[g].idx;
        assign f_valid[g] = fld[g].valid;
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int k = 0; k < NUM_CONT; k++) begin
                cont_6b[k] <= '0;
                cont_4b[k] <= '0;
                cont_2b[k] <= '0;
            end
        end else if (clear_i) begin
            for (int k = 0; k < NUM_CONT; k++) begin
                cont_6b[k] <= '0;
                cont_4b[k] <= '0;
                cont_2b[k] <= '0;
            end
        end else if (load_i) begin
            // slot order, so a later slot overrides on the same container
            for (int s = 0; s < NUM_ACT; s++) begin
                if (f_valid[s]) begin
                    case (f_type[s])
                        C2B:     cont_2b[f_idx[s]] <= f_val[s][15:0];
                        C4B:     cont_4b[f_idx[s]] <= f_val[s][31:0];
                        C6B:     cont_6b[f_idx[s]] <= f_val[s][47:0];
                        default: ;
                    endcase
                end
            end
        end
    end

    // big-endian containers, highest index at the top
    always_comb begin
        for (int k = 0; k < NUM_CONT; k++) begin
            pack_6b[48*k +: 48] = byte_swap(cont_6b[k], 6);
            pack_4b[32*k +: 32] = 32'(byte_swap(field_val_t'(cont_4b[k]), 4));
            pack_2b[16*k +: 16] = 16'(byte_swap(field_val_t'(cont_2b[k]), 2));
        end
    end

    assign phv_o = {pack_6b, pack_4b, pack_2b, {PAD_HI_W{1'b0}}, vlan_i, {PAD_LO_W{1'b0}}};

endmodule

`default_nettype wire

// File: project.f
common/parser_pkg.sv
common/field_if.sv
src/seg_counter.sv
src/parse_fsm.sv
src/hdr_buffer.sv
extract/field_extractor.sv
extract/phv_assembler.sv
table/action_ram.sv
table/ctrl_table_writer.sv
src/parser_top.sv
bench/parser_tb.sv

// File: src/hdr_buffer.sv
`default_nettype none
`timescale 1ns/10ps

module hdr_buffer (
    input  wire                    axis_clk,
    input  wire                    aresetn,
    input  wire parser_pkg::data_t tdata_i,
    input  wire                    tlast_i,
    input  wire                    first_beat_i,
    input  wire                    second_beat_i,
    output parser_pkg::hdr_t       hdr_o,
    output parser_pkg::vlan_t      vlan_o
);
    import parser_pkg::*;

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            hdr_o  <= '0;
            vlan_o <= '0;
        end else if (first_beat_i) begin
            hdr_o[DATA_W-1:0] <= tdata_i;
            vlan_o            <= tdata_i[VLAN_LSB +: $bits(vlan_t)];
            // single-beat packet, upper bytes read as zero
            if (tlast_i) begin
                hdr_o[HDR_W-1:DATA_W] <= '0;
            end
        end else if (second_beat_i) begin
            hdr_o[HDR_W-1:DATA_W] <= tdata_i;
        end
    end

endmodule

`default_nettype wire

// File: src/parse_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module parse_fsm (
    input  wire  axis_clk,
    input  wire  aresetn,
    input  wire  first_beat_i,
    input  wire  m_ready_i,
    output logic start_o,
    output logic clear_o,
    output logic load_o,
    output logic tready_o,
    output logic phv_valid_o
);
    import parser_pkg::*;

    parse_state_e state;

    assign clear_o = (state == IDLE_S);
    assign load_o  = (state == PHVGEN_S);

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= IDLE_S;
            start_o     <= 1'b0;
            tready_o    <= 1'b1;
            phv_valid_o <= 1'b0;
        end else begin
            // extractors fire once the second beat has landed
            start_o     <= (state == WAIT1_S);
            phv_valid_o <= 1'b0;
            case (state)
                IDLE_S: begin
                    if (first_beat_i) begin
                        state    <= WAIT1_S;
                        tready_o <= 1'b0;
                    end
                end
                WAIT1_S: state <= WAIT2_S;
                WAIT2_S: state <= PHVGEN_S;
                PHVGEN_S, HALT_S: begin
                    // hold the PHV until the consumer is ready
                    if (m_ready_i) begin
                        phv_valid_o <= 1'b1;
                        tready_o    <= 1'b1;
                        state       <= IDLE_S;
                    end else begin
                        state <= HALT_S;
                    end
                end
                default: state <= IDLE_S;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/parser_top.sv
`default_nettype none
`timescale 1ns/10ps

module parser_top #(
    parameter logic [2:0] PARSER_ID = 3'd0
) (
    input  wire                     axis_clk,
    input  wire                     aresetn,

    input  wire parser_pkg::data_t  s_axis_tdata_i,
    input  wire                     s_axis_tvalid_i,
    input  wire                     s_axis_tlast_i,
    output logic                    s_axis_tready_o,

    output logic                    phv_valid_o,
    output parser_pkg::phv_t        phv_o,
    input  wire                     m_axis_tready_i,

    input  wire parser_pkg::data_t  c_s_axis_tdata_i,
    input  wire                     c_s_axis_tvalid_i,
    input  wire                     c_s_axis_tlast_i
);
    import parser_pkg::*;

    logic      first_beat;
    logic      second_beat;
    logic      start;
    logic      clear;
    logic      load;
    hdr_t      hdr;
    vlan_t     vlan;
    tbl_addr_t rd_addr;
    entry_t    act_entry;
    logic      wr_en;
    tbl_addr_t wr_addr;
    entry_t    wr_data;

    field_if fld_bus [NUM_ACT] ();

    // table index comes from VLAN bits 8:4 of the live first beat
    assign rd_addr = s_axis_tdata_i[VLAN_LSB+4 +: $bits(tbl_addr_t)];

    seg_counter u_seg_counter (
        .axis_clk      (axis_clk),
        .aresetn       (aresetn),
        .tvalid_i      (s_axis_tvalid_i),
        .first_beat_o  (first_beat),
        .second_beat_o (second_beat)
    );

    parse_fsm u_parse_fsm (
        .axis_clk    (axis_clk),
        .aresetn     (aresetn),
        .first_beat_i(first_beat),
        .m_ready_i   (m_axis_tready_i),
        .start_o     (start),
        .clear_o     (clear),
        .load_o      (load),
        .tready_o    (s_axis_tready_o),
        .phv_valid_o (phv_valid_o)
    );

    hdr_buffer u_hdr_buffer (
        .axis_clk     (axis_clk),
        .aresetn      (aresetn),
        .tdata_i      (s_axis_tdata_i),
        .tlast_i      (s_axis_tlast_i),
        .first_beat_i (first_beat),
        .second_beat_i(second_beat),
        .hdr_o        (hdr),
        .vlan_o       (vlan)
    );

    action_ram u_action_ram (
        .axis_clk (axis_clk),
        .wr_en_i  (wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data),
        .rd_en_i  (first_beat),
        .rd_addr_i(rd_addr),
        .rd_data_o(act_entry)
    );

    ctrl_table_writer #(
        .PARSER_ID(PARSER_ID)
    ) u_ctrl_table_writer (
        .axis_clk (axis_clk),
        .aresetn  (aresetn),
        .tdata_i  (c_s_axis_tdata_i),
        .tvalid_i (c_s_axis_tvalid_i),
        .tlast_i  (c_s_axis_tlast_i),
        .wr_en_o  (wr_en),
        .wr_addr_o(wr_addr),
        .wr_data_o(wr_data)
    );

    // slot 0 sits at the top of the entry
    for (genvar g = 0; g < NUM_ACT; g++) begin : g_extract
        field_extractor u_field_extractor (
            .axis_clk(axis_clk),
            .aresetn (aresetn),
            .hdr_i   (hdr),
            .action_i(act_entry[ENTRY_W-1-ACT_W*g -: ACT_W]),
            .start_i (start),
            .fld     (fld_bus[g])
        );
    end

    phv_assembler u_phv_assembler (
        .axis_clk(axis_clk),
        .aresetn (aresetn),
        .clear_i (clear),
        .load_i  (load),
        .vlan_i  (vlan),
        .fld     (fld_bus),
        .phv_o   (phv_o)
    );

endmodule

`default_nettype wire

// File: src/seg_counter.sv
`default_nettype none
`timescale 1ns/10ps

module seg_counter (
    input  wire  axis_clk,
    input  wire  aresetn,
    input  wire  tvalid_i,
    output logic first_beat_o,
    output logic second_beat_o
);

    logic       tvalid_q;
    logic [1:0] beat_cnt;

    // rising tvalid marks a new packet
    assign first_beat_o  = tvalid_i & ~tvalid_q;
    assign second_beat_o = tvalid_i & tvalid_q & (beat_cnt == 2'd0);

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            tvalid_q <= 1'b0;
            // saturated count means no packet in flight
            beat_cnt <= 2'd3;
        end else begin
            tvalid_q <= tvalid_i;
            if (first_beat_o) begin
                beat_cnt <= 2'd0;
            end else if (tvalid_i && beat_cnt != 2'd3) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: table/action_ram.sv
`default_nettype none
`timescale 1ns/10ps

module action_ram (
    input  wire                        axis_clk,
    input  wire                        wr_en_i,
    input  wire parser_pkg::tbl_addr_t wr_addr_i,
    input  wire parser_pkg::entry_t    wr_data_i,
    input  wire                        rd_en_i,
    input  wire parser_pkg::tbl_addr_t rd_addr_i,
    output parser_pkg::entry_t         rd_data_o
);
    import parser_pkg::*;

    entry_t mem [TBL_DEPTH];

    always_ff @(posedge axis_clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read port holds its last entry between packets
    always_ff @(posedge axis_clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

// File: table/ctrl_table_writer.sv
`default_nettype none
`timescale 1ns/10ps

module ctrl_table_writer #(
    parameter logic [2:0] PARSER_ID = 3'd0
) (
    input  wire                    axis_clk,
    input  wire                    aresetn,
    input  wire parser_pkg::data_t tdata_i,
    input  wire                    tvalid_i,
    input  wire                    tlast_i,
    output logic                   wr_en_o,
    output parser_pkg::tbl_addr_t  wr_addr_o,
    output parser_pkg::entry_t     wr_data_o
);
    import parser_pkg::*;

    typedef enum logic [1:0] {
        CW_IDLE,
        CW_WRITE,
        CW_SKIP
    } cw_state_e;

    cw_state_e state;
    tbl_addr_t wr_idx;
    entry_t    entry_be;
    logic      hdr_match;

    assign hdr_match = (tdata_i[MOD_ID_LSB +: 3] == PARSER_ID) &&
                       (tdata_i[CTRL_FLAG_LSB +: 16] == CTRL_FLAG);

    // beat byte 0 becomes the top byte of the entry
    always_comb begin
        for (int j = 0; j < ENTRY_W/8; j++) begin
            entry_be[ENTRY_W-1-8*j -: 8] = tdata_i[8*j +: 8];
        end
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= CW_IDLE;
            wr_idx    <= '0;
            wr_en_o   <= 1'b0;
            wr_addr_o <= '0;
        end else begin
            wr_en_o <= 1'b0;
            case (state)
                CW_IDLE: begin
                    if (tvalid_i && !tlast_i) begin
                        if (hdr_match) begin
                            wr_idx <= tdata_i[INDEX_LSB +: $bits(tbl_addr_t)];
                            state  <= CW_WRITE;
                        end else begin
                            // not for us, drop the rest of the packet
                            state <= CW_SKIP;
                        end
                    end
                end
                CW_WRITE: begin
                    if (tvalid_i) begin
                        wr_en_o   <= 1'b1;
                        wr_addr_o <= wr_idx;
                        wr_idx    <= wr_idx + tbl_addr_t'(1);
                        if (tlast_i) begin
                            state <= CW_IDLE;
                        end
                    end
                end
                CW_SKIP: begin
                    if (tvalid_i && tlast_i) begin
                        state <= CW_IDLE;
                    end
                end
                default: state <= CW_IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (state == CW_WRITE && tvalid_i) begin
            wr_data_o <= entry_be;
        end
    end

endmodule

`default_nettype wire
